//--- i2c_slave_pkg.sv
`default_nettype none

package i2c_slave_pkg;

    // transaction states
    typedef enum logic [2:0]
    {
        IDLE,
        ADDR,
        REG_PTR,
        WR_DATA,
        RD_DATA,
        WAIT_STOP
    } fsm_state_t;

    localparam int BYTE_W       = 8;
    localparam int WORD_W       = 16;
    localparam int NUM_WORDS    = 4;  // r/w words at byte addresses 0x00..0x07
    localparam int LOCAL_ADDR_W = 3;

    // register map
    localparam logic [BYTE_W-1:0] RO_BASE      = 8'h08;  // first read-only byte
    localparam logic [BYTE_W-1:0] UNMAPPED_VAL = 8'hFF;

    // defaults for the top level parameters
    localparam logic [6:0] DEFAULT_SLAVE_ADDR   = 7'h50;
    localparam int         DEFAULT_DEBOUNCE_LEN = 10;  // ~208 ns at 48 MHz

endpackage

`default_nettype wire

//--- i2c_line_filter.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_line_filter #(
    parameter int DEBOUNCE_LEN = i2c_slave_pkg::DEFAULT_DEBOUNCE_LEN
) (
    input  logic CLOCK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_filt,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det
);

    localparam int SCL_I = 0;
    localparam int SDA_I = 1;

    logic [1:0][DEBOUNCE_LEN-1:0] pipe;  // raw sample history per line
    logic [1:0]                   raw;
    logic [1:0]                   filt;    // debounced levels
    logic [1:0]                   filt_q;  // previous debounced levels
    logic                         sda_rise;
    logic                         sda_fall;
    logic                         scl_high;

    assign raw = {sda, scl};

    // level changes only when the older samples of the window all agree
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            pipe   <= '1;  // idle bus is high
            filt   <= 2'b11;
            filt_q <= 2'b11;
        end
        else
        begin
            for (int i = 0; i < 2; i++)
            begin
                pipe[i] <= {pipe[i][DEBOUNCE_LEN-2:0], raw[i]};
                if (&pipe[i][DEBOUNCE_LEN-1:1])
                    filt[i] <= 1'b1;
                else if (!(|pipe[i][DEBOUNCE_LEN-1:1]))
                    filt[i] <= 1'b0;
            end
            filt_q <= filt;
        end
    end

    assign sda_filt = filt[SDA_I];

    assign scl_rise = filt[SCL_I] & ~filt_q[SCL_I];
    assign scl_fall = ~filt[SCL_I] & filt_q[SCL_I];
    assign sda_rise = filt[SDA_I] & ~filt_q[SDA_I];
    assign sda_fall = ~filt[SDA_I] & filt_q[SDA_I];

    // scl stable high across the sda edge
    assign scl_high = filt[SCL_I] & filt_q[SCL_I];

    assign start_det = scl_high & sda_fall;
    assign stop_det  = scl_high & sda_rise;

endmodule

`default_nettype wire

//--- i2c_bit_counter.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_counter (
    input  logic CLOCK,
    input  logic RESET,
    input  logic clear,
    input  logic scl_rise,
    input  logic scl_fall,
    output logic sample,
    output logic shift,
    output logic ack_slot,
    output logic byte_done
);

    logic [3:0] cnt;  // rising scl edges seen in this byte

    // the fall right after START sees cnt 0 and marks nothing
    assign sample    = scl_rise & (cnt < 4'd8);
    assign shift     = scl_fall & (cnt >= 4'd1) & (cnt <= 4'd7);
    assign byte_done = scl_fall & (cnt == 4'd9);

    always_ff @(posedge CLOCK)
    begin
        if (RESET || clear)
        begin
            cnt      <= 4'd0;
            ack_slot <= 1'b0;
        end
        else
        begin
            if (byte_done)
                cnt <= 4'd0;
            else if (scl_rise)
                cnt <= cnt + 4'd1;

            if (scl_fall && cnt == 4'd8)
                ack_slot <= 1'b1;  // ninth clock begins
            else if (byte_done)
                ack_slot <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- i2c_byte_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_shifter (
    input  logic                              CLOCK,
    input  logic                              RESET,
    input  logic                              sda_filt,
    input  logic                              sample,
    input  logic                              shift,
    input  logic                              ack_slot,
    input  logic                              load,
    input  logic [i2c_slave_pkg::BYTE_W-1:0]  load_byte,
    input  logic                              tx_en,
    input  logic                              ack_en,
    output logic [i2c_slave_pkg::BYTE_W-1:0]  rx_byte,
    output logic                              sda_pull
);

    import i2c_slave_pkg::*;

    logic [BYTE_W-1:0] tx_reg;

    // receive, msb first
    always_ff @(posedge CLOCK)
    begin
        if (sample)
            rx_byte <= {rx_byte[BYTE_W-2:0], sda_filt};
    end

    // transmit register, msb on the line
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            tx_reg <= '1;
        end
        else if (load)
        begin
            tx_reg <= load_byte;
        end
        else if (shift)
        begin
            tx_reg <= {tx_reg[BYTE_W-2:0], 1'b1};  // release after last bit
        end
    end

    // open drain, only ever pulls low
    always_comb
    begin
        if (ack_slot)
            sda_pull = ack_en;
        else
            sda_pull = tx_en & ~tx_reg[BYTE_W-1];
    end

endmodule

`default_nettype wire

//--- i2c_slave_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_fsm #(
    parameter logic [6:0] SLAVE_ADDR = i2c_slave_pkg::DEFAULT_SLAVE_ADDR
) (
    input  logic                              CLOCK,
    input  logic                              RESET,
    input  logic                              start_det,
    input  logic                              stop_det,
    input  logic                              byte_done,
    input  logic                              ack_slot,
    input  logic [i2c_slave_pkg::BYTE_W-1:0]  rx_byte,
    output logic                              byte_clear,
    output logic                              load,
    output logic                              tx_en,
    output logic                              ack_en,
    output logic [i2c_slave_pkg::BYTE_W-1:0]  reg_ptr,
    output logic                              wr_strobe
);

    import i2c_slave_pkg::*;

    fsm_state_t state;
    logic       ack_q;       // ack_slot delayed
    logic       addr_match;

    assign addr_match = (rx_byte[BYTE_W-1:1] == SLAVE_ADDR);

    // acked bytes: matching address, pointer, first data byte
    assign ack_en = ((state == ADDR) && addr_match)
                  || (state == REG_PTR)
                  || (state == WR_DATA);

    // hold off one cycle while the transmit register loads
    assign tx_en = (state == RD_DATA) && !load;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state      <= IDLE;
            ack_q      <= 1'b0;
            byte_clear <= 1'b0;
            load       <= 1'b0;
            wr_strobe  <= 1'b0;
            reg_ptr    <= '0;
        end
        else
        begin
            ack_q      <= ack_slot;
            byte_clear <= 1'b0;
            load       <= 1'b0;
            wr_strobe  <= (state == WR_DATA) && ack_slot && !ack_q;  // data byte complete

            if (start_det)
            begin
                state <= ADDR;  // also repeated start
            end
            else if (stop_det)
            begin
                state      <= IDLE;
                byte_clear <= 1'b1;
            end
            else if (byte_done)
            begin
                case (state)
                    ADDR:
                    begin
                        if (!addr_match)
                        begin
                            state      <= IDLE;  // not for us
                            byte_clear <= 1'b1;
                        end
                        else if (rx_byte[0])
                        begin
                            state <= RD_DATA;
                            load  <= 1'b1;
                        end
                        else
                        begin
                            state <= REG_PTR;
                        end
                    end
                    REG_PTR:
                    begin
                        reg_ptr <= rx_byte;  // kept across transactions
                        state   <= WR_DATA;
                    end
                    WR_DATA, RD_DATA:
                    begin
                        state <= WAIT_STOP;  // no bursts
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- i2c_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_reg_file (
    input  logic                                    CLOCK,
    input  logic                                    RESET,
    input  logic [i2c_slave_pkg::BYTE_W-1:0]        reg_ptr,
    input  logic                                    wr_strobe,
    input  logic [i2c_slave_pkg::BYTE_W-1:0]        wr_byte,
    output logic [i2c_slave_pkg::BYTE_W-1:0]        rd_byte,
    input  logic                                    local_rd_en,
    input  logic [i2c_slave_pkg::LOCAL_ADDR_W-1:0]  local_addr,
    output logic [i2c_slave_pkg::WORD_W-1:0]        local_data,
    output logic                                    mclk_speed,
    output logic                                    idle_mode,
    output logic [1:0]                              mclk_mode,
    output logic [4:0]                              rows_delay
);

    import i2c_slave_pkg::*;

    localparam int WIDX_W = $clog2(NUM_WORDS);

    localparam logic [WORD_W-1:0] WORD_INIT [NUM_WORDS] = '{16'h8095, 16'h031D, 16'h0, 16'h0};
    localparam logic [BYTE_W-1:0] RO_BYTES  [4]         = '{8'h10, 8'h20, 8'h30, 8'h40};

    logic [WORD_W-1:0] words [NUM_WORDS];
    logic [WIDX_W-1:0] widx;     // word holding reg_ptr
    logic [BYTE_W-1:0] ro_off;

    assign widx   = reg_ptr[WIDX_W:1];
    assign ro_off = reg_ptr - RO_BASE;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            words <= WORD_INIT;
        end
        else if (wr_strobe && reg_ptr < RO_BASE)
        begin
            if (reg_ptr[0])
                words[widx][BYTE_W-1:0] <= wr_byte;       // odd address, low byte
            else
                words[widx][WORD_W-1:BYTE_W] <= wr_byte;
        end
    end

    always_comb
    begin
        if (reg_ptr < RO_BASE)
            rd_byte = reg_ptr[0] ? words[widx][BYTE_W-1:0] : words[widx][WORD_W-1:BYTE_W];
        else if (ro_off < 8'd4)
            rd_byte = RO_BYTES[ro_off[1:0]];
        else
            rd_byte = UNMAPPED_VAL;
    end

    // local word port, holds between reads
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
            local_data <= '0;
        else if (local_rd_en)
            local_data <= (local_addr < NUM_WORDS) ? words[local_addr[WIDX_W-1:0]] : '0;
    end

    // config fields in word 1
    assign mclk_speed = words[1][0];
    assign idle_mode  = words[1][1];
    assign mclk_mode  = words[1][7:6];
    assign rows_delay = words[1][15:11];

endmodule

`default_nettype wire

//--- i2c_slave_top.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_top #(
    parameter logic [6:0] SLAVE_ADDR   = i2c_slave_pkg::DEFAULT_SLAVE_ADDR,
    parameter int         DEBOUNCE_LEN = i2c_slave_pkg::DEFAULT_DEBOUNCE_LEN
) (
    input  logic                                    CLOCK,
    input  logic                                    RESET,
    input  logic                                    scl,
    inout  wire                                     sda,
    input  logic                                    local_rd_en,
    input  logic [i2c_slave_pkg::LOCAL_ADDR_W-1:0]  local_addr,
    output logic [i2c_slave_pkg::WORD_W-1:0]        local_data,
    output logic                                    mclk_speed,
    output logic                                    idle_mode,
    output logic [1:0]                              mclk_mode,
    output logic [4:0]                              rows_delay
);

    import i2c_slave_pkg::*;

    logic              sda_filt;
    logic              scl_rise;
    logic              scl_fall;
    logic              start_det;
    logic              stop_det;
    logic              sample;
    logic              shift;
    logic              ack_slot;
    logic              byte_done;
    logic              byte_clear;
    logic              cnt_clear;
    logic              load;
    logic              tx_en;
    logic              ack_en;
    logic              sda_pull;
    logic              wr_strobe;
    logic [BYTE_W-1:0] rx_byte;
    logic [BYTE_W-1:0] reg_ptr;
    logic [BYTE_W-1:0] rd_byte;

    assign sda       = sda_pull ? 1'b0 : 1'bz;  // open drain pad
    assign cnt_clear = byte_clear | start_det;

    i2c_line_filter #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_line_filter (
        .CLOCK(CLOCK), .RESET(RESET), .scl(scl), .sda(sda), .sda_filt(sda_filt),
        .scl_rise(scl_rise), .scl_fall(scl_fall), .start_det(start_det), .stop_det(stop_det)
    );

    i2c_bit_counter u_bit_counter (
        .CLOCK(CLOCK), .RESET(RESET), .clear(cnt_clear), .scl_rise(scl_rise),
        .scl_fall(scl_fall), .sample(sample), .shift(shift), .ack_slot(ack_slot),
        .byte_done(byte_done)
    );

    i2c_byte_shifter u_byte_shifter (
        .CLOCK(CLOCK), .RESET(RESET), .sda_filt(sda_filt), .sample(sample), .shift(shift),
        .ack_slot(ack_slot), .load(load), .load_byte(rd_byte), .tx_en(tx_en),
        .ack_en(ack_en), .rx_byte(rx_byte), .sda_pull(sda_pull)
    );

    i2c_slave_fsm #(.SLAVE_ADDR(SLAVE_ADDR)) u_slave_fsm (
        .CLOCK(CLOCK), .RESET(RESET), .start_det(start_det), .stop_det(stop_det),
        .byte_done(byte_done), .ack_slot(ack_slot), .rx_byte(rx_byte),
        .byte_clear(byte_clear), .load(load), .tx_en(tx_en), .ack_en(ack_en),
        .reg_ptr(reg_ptr), .wr_strobe(wr_strobe)
    );

    i2c_reg_file u_reg_file (
        .CLOCK(CLOCK), .RESET(RESET), .reg_ptr(reg_ptr), .wr_strobe(wr_strobe),
        .wr_byte(rx_byte), .rd_byte(rd_byte), .local_rd_en(local_rd_en),
        .local_addr(local_addr), .local_data(local_data), .mclk_speed(mclk_speed),
        .idle_mode(idle_mode), .mclk_mode(mclk_mode), .rows_delay(rows_delay)
    );

endmodule

`default_nettype wire

//--- tb_i2c_slave.sv
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_slave;

    localparam int         HALF        = 40;    // scl half period in clocks
    localparam int         HOLD        = 10;    // data hold after scl fall
    localparam int         BUS_LIMIT   = 4 * HALF;
    localparam int         DRAIN_LIMIT = 200;
    localparam logic [6:0] DEV_ADDR    = 7'h50;
    localparam logic [6:0] WRONG_ADDR  = 7'h23;

    logic        CLOCK;
    logic        RESET;
    logic        scl;
    logic        sda_low;  // master pulls sda
    wire         sda;
    logic        local_rd_en;
    logic [2:0]  local_addr;
    logic [15:0] local_data;
    logic        mclk_speed;
    logic        idle_mode;
    logic [1:0]  mclk_mode;
    logic [4:0]  rows_delay;

    logic [7:0]  model [12];  // byte image of the register map
    logic [7:0]  read_addr_q [$];
    logic [7:0]  read_data_q [$];
    logic [31:0] lcg_state = 32'hc72f_71c6;
    int          checks    = 0;
    int          errs      = 0;
    int          test_checks;
    int          test_errs;

    assign sda = sda_low ? 1'b0 : 1'bz;
    pullup (sda);

    i2c_slave_top u_i2c_slave_top (
        .CLOCK(CLOCK), .RESET(RESET), .scl(scl), .sda(sda), .local_rd_en(local_rd_en),
        .local_addr(local_addr), .local_data(local_data), .mclk_speed(mclk_speed),
        .idle_mode(idle_mode), .mclk_mode(mclk_mode), .rows_delay(rows_delay)
    );

    initial
    begin
        CLOCK = 1'b0;
        forever #20 CLOCK = ~CLOCK;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // reference: r/w words and read-only bytes, everything else 0xff
    function automatic logic [7:0] expected_byte(input logic [7:0] addr);
        if (addr < 8'd12)
            return model[addr];
        return 8'hFF;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK);
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic wait_sda_released();
        int n;
        n = 0;
        while (sda !== 1'b1 && n < BUS_LIMIT)
        begin
            @(posedge CLOCK);
            n++;
        end
        if (sda !== 1'b1)
            abort_run("slave keeps sda low before start");
    endtask

    // one scl pulse, scl low on entry and exit
    task automatic clock_bit(input logic b, output logic sampled);
        wait_cycles(HOLD);
        sda_low <= ~b;
        wait_cycles(HALF - HOLD);
        scl <= 1'b1;
        wait_cycles(HALF / 2);
        sampled = (sda !== 1'b0);
        wait_cycles(HALF / 2);
        scl <= 1'b0;
    endtask

    task automatic bus_start();  // also serves as repeated start
        wait_sda_released();
        sda_low <= 1'b0;
        wait_cycles(HALF);
        scl <= 1'b1;
        wait_cycles(HALF);
        sda_low <= 1'b1;
        wait_cycles(HALF);
        scl <= 1'b0;
    endtask

    task automatic bus_stop();
        wait_cycles(HOLD);
        sda_low <= 1'b1;
        wait_cycles(HALF - HOLD);
        scl <= 1'b1;
        wait_cycles(HALF);
        sda_low <= 1'b0;
        wait_cycles(2 * HALF);  // bus free time
    endtask

    task automatic write_byte(input logic [7:0] b, output logic acked);
        logic s;
        for (int i = 7; i >= 0; i--)
            clock_bit(b[i], s);
        clock_bit(1'b1, s);
        acked = ~s;
    endtask

    task automatic read_byte(input logic nack, output logic [7:0] d);
        logic s;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, s);
            d[i] = s;
        end
        clock_bit(nack, s);
    endtask

    task automatic expect_ack(input logic acked, input logic want, input string what);
        checks++;
        assert (acked == want)
        else
        begin
            $display("%s: slave %s", what, want ? "gave no ack" : "acked unexpectedly");
            errs++;
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
            errs++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        logic a0, a1, a2;
        bus_start();
        write_byte({DEV_ADDR, 1'b0}, a0);
        write_byte(addr, a1);
        write_byte(data, a2);
        bus_stop();
        expect_ack(a0 & a1 & a2, 1'b1, $sformatf("write to 0x%h", addr));
        if (addr < 8'd8)
            model[addr] = data;  // read-only and unmapped stay as they are
    endtask

    task automatic set_pointer(input logic [7:0] addr);
        logic a0, a1;
        bus_start();
        write_byte({DEV_ADDR, 1'b0}, a0);
        write_byte(addr, a1);
        bus_stop();
        expect_ack(a0 & a1, 1'b1, "pointer write");
    endtask

    // read at the current pointer, checked later by the compare process
    task automatic read_current(input logic [7:0] addr);
        logic       a0;
        logic [7:0] d;
        bus_start();
        write_byte({DEV_ADDR, 1'b1}, a0);
        read_byte(1'b1, d);
        bus_stop();
        expect_ack(a0, 1'b1, "read address");
        read_addr_q.push_back(addr);
        read_data_q.push_back(d);
    endtask

    task automatic read_reg(input logic [7:0] addr);
        logic       a0, a1, a2;
        logic [7:0] d;
        bus_start();
        write_byte({DEV_ADDR, 1'b0}, a0);
        write_byte(addr, a1);
        bus_start();
        write_byte({DEV_ADDR, 1'b1}, a2);
        read_byte(1'b1, d);
        bus_stop();
        expect_ack(a0 & a1 & a2, 1'b1, $sformatf("read setup 0x%h", addr));
        read_addr_q.push_back(addr);
        read_data_q.push_back(d);
    endtask

    task automatic compare_local(input logic [2:0] a);
        logic [15:0] exp;
        @(posedge CLOCK);
        local_rd_en <= 1'b1;
        local_addr  <= a;
        @(posedge CLOCK);
        local_rd_en <= 1'b0;
        @(posedge CLOCK);
        exp = (a < 3'd4) ? {model[2 * a], model[2 * a + 1]} : 16'h0;
        check_value($sformatf("local_data[%0d]", a), local_data, exp);
    endtask

    task automatic compare_config();
        logic [15:0] w1;
        w1 = {model[2], model[3]};
        check_value("mclk_speed", mclk_speed, w1[0]);
        check_value("idle_mode", idle_mode, w1[1]);
        check_value("mclk_mode", mclk_mode, w1[7:6]);
        check_value("rows_delay", rows_delay, w1[15:11]);
    endtask

    task automatic begin_test();
        test_checks = checks;
        test_errs   = errs;
    endtask

    // pending bus reads are compared before the test line goes out
    task automatic end_test(input int num, input string name);
        int n;
        n = 0;
        while (read_data_q.size() != 0 && n < DRAIN_LIMIT)
        begin
            @(posedge CLOCK);
            n++;
        end
        if (read_data_q.size() != 0)
            abort_run("compare queue never drained");
        else
            $display("test %0d %s: %0d checks, %0d errors", num, name,
                     checks - test_checks, errs - test_errs);
    endtask

    // compare process for bytes read over the bus
    initial
    begin
        logic [7:0] a;
        logic [7:0] d;
        forever
        begin
            @(posedge CLOCK);
            if (read_data_q.size() != 0)
            begin
                a = read_addr_q.pop_front();
                d = read_data_q.pop_front();
                check_value($sformatf("rd_byte@0x%h", a), d, expected_byte(a));
            end
        end
    end

    initial
    begin
        RESET       = 1'b1;
        scl         = 1'b1;
        sda_low     = 1'b0;
        local_rd_en = 1'b0;
        local_addr  = '0;
        model = '{8'h80, 8'h95, 8'h03, 8'h1D, 8'h00, 8'h00, 8'h00, 8'h00,
                  8'h10, 8'h20, 8'h30, 8'h40};
        wait_cycles(5);
        RESET <= 1'b0;
        wait_cycles(4);

        begin_test();
        for (int a = 0; a < 8; a++)
            compare_local(a);
        compare_config();
        end_test(1, "reset state");

        begin_test();
        for (int a = 0; a < 8; a++)
            write_reg(a, next_random() >> 24);
        for (int a = 0; a < 8; a++)
            compare_local(a);
        compare_config();
        end_test(2, "write then local read");

        begin_test();
        for (int a = 0; a < 12; a++)
            read_reg(a);
        read_reg(8'h0C);
        read_reg(8'h20);
        read_reg(8'h7F);
        read_reg(8'hFF);
        end_test(3, "read with repeated start");

        begin_test();
        begin : wrong_addr_xfer
            logic a0, a1, a2;
            bus_start();
            write_byte({WRONG_ADDR, 1'b0}, a0);
            write_byte(8'h02, a1);
            write_byte(~model[2], a2);  // would change word 1 if taken
            bus_stop();
            expect_ack(a0 | a1 | a2, 1'b0, "wrong address");
        end
        for (int a = 0; a < 4; a++)
            compare_local(a);
        end_test(4, "wrong address");

        begin_test();
        for (int a = 8; a < 12; a++)
            write_reg(a, next_random() >> 24);
        write_reg(8'h20, next_random() >> 24);
        for (int a = 0; a < 12; a++)
            read_reg(a);
        read_reg(8'h20);
        for (int a = 0; a < 4; a++)
            compare_local(a);
        end_test(5, "read-only and unmapped writes");

        begin_test();
        set_pointer(8'h05);
        read_current(8'h05);
        set_pointer(8'h09);
        read_current(8'h09);
        end_test(6, "pointer persistence");

        $display("total %0d checks, %0d errors", checks, errs);
        if (errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
i2c_slave_pkg.sv
i2c_line_filter.sv
i2c_bit_counter.sv
i2c_byte_shifter.sv
i2c_slave_fsm.sv
i2c_reg_file.sv
i2c_slave_top.sv
tb_i2c_slave.sv

//--- Bender.yml
package:
  name: i2c_slave

sources:
  - i2c_slave_pkg.sv
  - i2c_line_filter.sv
  - i2c_bit_counter.sv
  - i2c_byte_shifter.sv
  - i2c_slave_fsm.sv
  - i2c_reg_file.sv
  - i2c_slave_top.sv
  - target: simulation
    files:
      - tb_i2c_slave.sv
